// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - common/rv_pkg.sv
  - idu/idu_normal.sv
  - idu/idu_system.sv
  - idu/idu.sv
  - hdl/regfile.sv
  - hdl/csr_file.sv
  - hdl/id_stage.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_id_stage.sv

// ==== common/rv_pkg.sv ====
package rv_pkg;

  localparam int INS_WIDTH = 32;
  localparam int CPU_WIDTH = 32;
  localparam int REG_ADDRW = 5;
  localparam int CSR_ADDRW = 12;

  // base opcodes, low 7 bits of the word.
  localparam logic [6:0] TYPE_OP     = 7'b0110011;
  localparam logic [6:0] TYPE_OPIMM  = 7'b0010011;
  localparam logic [6:0] TYPE_LUI    = 7'b0110111;
  localparam logic [6:0] TYPE_AUIPC  = 7'b0010111;
  localparam logic [6:0] TYPE_LOAD   = 7'b0000011;
  localparam logic [6:0] TYPE_STORE  = 7'b0100011;
  localparam logic [6:0] TYPE_BRANCH = 7'b1100011;
  localparam logic [6:0] TYPE_JAL    = 7'b1101111;
  localparam logic [6:0] TYPE_JALR   = 7'b1100111;
  localparam logic [6:0] TYPE_SYS    = 7'b1110011;

  localparam logic [CSR_ADDRW-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDRW-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDRW-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDRW-1:0] CSR_MCAUSE  = 12'h342;

  localparam logic [CPU_WIDTH-1:0] CAUSE_ECALL_M = 32'd11;

  // 17 operations, so the code needs 5 bits.
  typedef enum logic [4:0] {
    EXU_NOP, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    BEQ, BNE, BLT, BGE, BLTU, BGEU
  } exu_opt_e;

  typedef enum logic [1:0] {
    EXU_SEL_REG,  // rs1, rs2.
    EXU_SEL_IMM,  // rs1, imm.
    EXU_SEL_PCI,  // pc, imm.
    EXU_SEL_PC4   // pc, 4.
  } exu_sel_e;

  typedef enum logic [3:0] {LSU_NOP, LB, LH, LW, LBU, LHU, SB, SH, SW} lsu_opt_e;

  typedef enum logic [1:0] {CSR_NOP, CSR_RW, CSR_RS, CSR_RC} csr_opt_e;

  typedef enum logic {CSR_SEL_REG, CSR_SEL_IMM} csr_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one word, six views.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } rv_ins_u;

  typedef struct packed {
    logic [REG_ADDRW-1:0] rdid;
    logic [REG_ADDRW-1:0] rs1id;
    logic [REG_ADDRW-1:0] rs2id;
    logic                 rdwen;
    logic [CPU_WIDTH-1:0] imm;
    exu_sel_e             exu_src_sel;
    exu_opt_e             exu_opt;
    lsu_opt_e             lsu_opt;
    logic                 brch;
    logic                 jal;
    logic                 jalr;
    logic                 sysins;
    logic [CSR_ADDRW-1:0] csrsid;
    logic                 csrsren;
    csr_opt_e             excsropt;
    csr_sel_e             excsrsrc;
    logic [CSR_ADDRW-1:0] csrdid;
    logic                 csrdwen;
    logic                 ecall;
    logic                 mret;
  } id_ctrl_t;

  typedef struct packed {
    logic                 wen;
    logic [REG_ADDRW-1:0] id;
    logic [CPU_WIDTH-1:0] data;
  } reg_wb_t;

  typedef struct packed {
    logic                 wen;
    logic [CSR_ADDRW-1:0] id;
    logic [CPU_WIDTH-1:0] data;
  } csr_wb_t;

endpackage

// ==== hdl/csr_file.sv ====
`timescale 1ns/10ps
module csr_file import rv_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic [CSR_ADDRW-1:0] i_csrsid,
  input  logic                 i_csrsren,
  input  csr_wb_t              i_wb,
  input  logic                 i_ecall,
  input  logic                 i_mret,
  input  logic [CPU_WIDTH-1:0] i_pc,
  output logic [CPU_WIDTH-1:0] o_rdata,
  output logic                 o_trap_valid,
  output logic [CPU_WIDTH-1:0] o_trap_pc
);

  logic [CPU_WIDTH-1:0] mstatus, mtvec, mepc, mcause;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (i_wb.wen) begin
        case (i_wb.id)
          CSR_MSTATUS: mstatus <= i_wb.data;
          CSR_MTVEC:   mtvec   <= i_wb.data;
          CSR_MEPC:    mepc    <= i_wb.data;
          CSR_MCAUSE:  mcause  <= i_wb.data;
          default: ;
        endcase
      end
      if (i_ecall) begin
        mepc   <= i_pc;  // overrides a same-edge write.
        mcause <= CAUSE_ECALL_M;
      end
    end
  end

  always_comb begin
    o_rdata = '0;
    if (i_csrsren) begin
      case (i_csrsid)
        CSR_MSTATUS: o_rdata = mstatus;
        CSR_MTVEC:   o_rdata = mtvec;
        CSR_MEPC:    o_rdata = mepc;
        CSR_MCAUSE:  o_rdata = mcause;
        default:     o_rdata = '0;
      endcase
    end
  end

  assign o_trap_valid = i_ecall || i_mret;
  assign o_trap_pc    = i_ecall ? mtvec : (i_mret ? mepc : '0);  // handler or return.

  // the decoder never flags both.
  a_ecall_mret_excl: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_ecall && i_mret));

endmodule

// ==== hdl/id_stage.sv ====
`timescale 1ns/10ps
module id_stage import rv_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  rv_ins_u              i_ins,
  input  logic [CPU_WIDTH-1:0] i_pc,
  input  reg_wb_t              i_reg_wb,
  input  csr_wb_t              i_csr_wb,
  output id_ctrl_t             o_ctrl,
  output logic [CPU_WIDTH-1:0] o_rs1_data,
  output logic [CPU_WIDTH-1:0] o_rs2_data,
  output logic [CPU_WIDTH-1:0] o_csr_rdata,
  output logic                 o_trap_valid,
  output logic [CPU_WIDTH-1:0] o_trap_pc
);

  id_ctrl_t ctrl;

  assign o_ctrl = ctrl;

  idu u_idu (
    .i_ins (i_ins),
    .o_ctrl(ctrl)
  );

  regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_rs1id   (ctrl.rs1id),
    .i_rs2id   (ctrl.rs2id),
    .i_wb      (i_reg_wb),    // from write-back.
    .o_rs1_data(o_rs1_data),
    .o_rs2_data(o_rs2_data)
  );

  csr_file u_csr_file (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_csrsid    (ctrl.csrsid),
    .i_csrsren   (ctrl.csrsren),
    .i_wb        (i_csr_wb),  // from execute.
    .i_ecall     (ctrl.ecall),
    .i_mret      (ctrl.mret),
    .i_pc        (i_pc),
    .o_rdata     (o_csr_rdata),
    .o_trap_valid(o_trap_valid),
    .o_trap_pc   (o_trap_pc)
  );

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps
module regfile import rv_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic [REG_ADDRW-1:0] i_rs1id,
  input  logic [REG_ADDRW-1:0] i_rs2id,
  input  reg_wb_t              i_wb,
  output logic [CPU_WIDTH-1:0] o_rs1_data,
  output logic [CPU_WIDTH-1:0] o_rs2_data
);

  localparam int NUM_REGS = 2 ** REG_ADDRW;

  logic [CPU_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wb.wen && i_wb.id != '0) begin
      regs[i_wb.id] <= i_wb.data;  // x0 never written.
    end
  end

  // no bypass, write shows up next cycle.
  assign o_rs1_data = (i_rs1id == '0) ? '0 : regs[i_rs1id];
  assign o_rs2_data = (i_rs2id == '0) ? '0 : regs[i_rs2id];

  // a write aimed at x0 leaves it zero afterwards.
  a_x0_zero: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_wb.wen && i_wb.id == '0) |=> (regs[0] == '0));

endmodule

// ==== idu/idu.sv ====
`timescale 1ns/10ps
module idu import rv_pkg::*; (
  input  rv_ins_u  i_ins,
  output id_ctrl_t o_ctrl
);

  // bits 31..7 of mret: funct12 = 0x302, rest zero.
  localparam logic [INS_WIDTH-8:0] MRET_HI = {12'h302, 13'b0};

  logic sysins;

  logic [REG_ADDRW-1:0] nom_rdid, nom_rs1id, nom_rs2id;
  logic                 nom_rdwen;
  logic [CPU_WIDTH-1:0] nom_imm;
  exu_sel_e             nom_exsrc;
  exu_opt_e             nom_exopt;
  lsu_opt_e             nom_lsu_opt;
  logic                 nom_brch, nom_jal, nom_jalr;

  logic [CSR_ADDRW-1:0] sys_csrsid, sys_csrdid;
  logic                 sys_csrsren, sys_csrdwen;
  logic [REG_ADDRW-1:0] sys_rs1id, sys_rdid;
  logic                 sys_rdwen;
  logic [CPU_WIDTH-1:0] sys_imm;
  csr_opt_e             sys_excsropt;
  csr_sel_e             sys_excsrsrc;

  assign sysins = (i_ins.r.opcode == TYPE_SYS);

  idu_normal u_idu_normal (
    .i_ins        (i_ins),
    .o_rdid       (nom_rdid),
    .o_rs1id      (nom_rs1id),
    .o_rs2id      (nom_rs2id),
    .o_rdwen      (nom_rdwen),
    .o_imm        (nom_imm),
    .o_exu_src_sel(nom_exsrc),
    .o_exu_opt    (nom_exopt),
    .o_lsu_opt    (nom_lsu_opt),
    .o_brch       (nom_brch),
    .o_jal        (nom_jal),
    .o_jalr       (nom_jalr)
  );

  idu_system u_idu_system (
    .i_ins     (i_ins),
    .o_csrsid  (sys_csrsid),
    .o_csrsren (sys_csrsren),
    .o_rs1id   (sys_rs1id),
    .o_imm     (sys_imm),
    .o_excsropt(sys_excsropt),
    .o_excsrsrc(sys_excsrsrc),
    .o_rdid    (sys_rdid),
    .o_rdwen   (sys_rdwen),
    .o_csrdid  (sys_csrdid),
    .o_csrdwen (sys_csrdwen)
  );

  always_comb begin
    o_ctrl.sysins      = sysins;
    o_ctrl.rdid        = sysins ? sys_rdid : nom_rdid;
    o_ctrl.rs1id       = sysins ? sys_rs1id : nom_rs1id;
    o_ctrl.rs2id       = sysins ? '0 : nom_rs2id;
    o_ctrl.rdwen       = sysins ? sys_rdwen : nom_rdwen;
    o_ctrl.imm         = sysins ? sys_imm : nom_imm;
    o_ctrl.exu_src_sel = sysins ? EXU_SEL_IMM : nom_exsrc;
    o_ctrl.exu_opt     = sysins ? EXU_NOP : nom_exopt;
    o_ctrl.lsu_opt     = sysins ? LSU_NOP : nom_lsu_opt;
    o_ctrl.brch        = sysins ? 1'b0 : nom_brch;  // no flow change here.
    o_ctrl.jal         = sysins ? 1'b0 : nom_jal;
    o_ctrl.jalr        = sysins ? 1'b0 : nom_jalr;
    o_ctrl.csrsid      = sysins ? sys_csrsid : '0;
    o_ctrl.csrsren     = sysins ? sys_csrsren : 1'b0;
    o_ctrl.excsropt    = sysins ? sys_excsropt : CSR_NOP;
    o_ctrl.excsrsrc    = sysins ? sys_excsrsrc : CSR_SEL_REG;
    o_ctrl.csrdid      = sysins ? sys_csrdid : '0;
    o_ctrl.csrdwen     = sysins ? sys_csrdwen : 1'b0;
    o_ctrl.ecall       = sysins && (i_ins[INS_WIDTH-1:7] == '0);
    o_ctrl.mret        = sysins && (i_ins[INS_WIDTH-1:7] == MRET_HI);
  end

  // normal decoder raises at most one flow flag.
  a_flow_onehot: assert final ($onehot0({nom_brch, nom_jal, nom_jalr}));

endmodule

// ==== idu/idu_normal.sv ====
`timescale 1ns/10ps
module idu_normal import rv_pkg::*; (
  input  rv_ins_u              i_ins,
  output logic [REG_ADDRW-1:0] o_rdid,
  output logic [REG_ADDRW-1:0] o_rs1id,
  output logic [REG_ADDRW-1:0] o_rs2id,
  output logic                 o_rdwen,
  output logic [CPU_WIDTH-1:0] o_imm,
  output exu_sel_e             o_exu_src_sel,
  output exu_opt_e             o_exu_opt,
  output lsu_opt_e             o_lsu_opt,
  output logic                 o_brch,
  output logic                 o_jal,
  output logic                 o_jalr
);

  logic [CPU_WIDTH-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0]           funct3;
  logic                 alt;

  assign funct3 = i_ins.r.funct3;
  assign alt    = i_ins.r.funct7[5];  // sub / sra select.

  assign imm_i = {{20{i_ins.i.imm_11_0[11]}}, i_ins.i.imm_11_0};
  assign imm_s = {{20{i_ins.s.imm_11_5[6]}}, i_ins.s.imm_11_5, i_ins.s.imm_4_0};
  assign imm_b = {{19{i_ins.b.imm_12}}, i_ins.b.imm_12, i_ins.b.imm_11,
                  i_ins.b.imm_10_5, i_ins.b.imm_4_1, 1'b0};
  assign imm_u = {i_ins.u.imm_31_12, 12'b0};
  assign imm_j = {{11{i_ins.j.imm_20}}, i_ins.j.imm_20, i_ins.j.imm_19_12,
                  i_ins.j.imm_11, i_ins.j.imm_10_1, 1'b0};

  // shared by OP and OP-IMM; sub only exists in register form.
  function automatic exu_opt_e alu_op(input logic [2:0] f3, input logic f7b5,
                                      input logic is_reg);
    case (f3)
      3'b000:  alu_op = (is_reg && f7b5) ? SUB : ADD;
      3'b001:  alu_op = SLL;
      3'b010:  alu_op = SLT;
      3'b011:  alu_op = SLTU;
      3'b100:  alu_op = XOR;
      3'b101:  alu_op = f7b5 ? SRA : SRL;
      3'b110:  alu_op = OR;
      default: alu_op = AND;
    endcase
  endfunction

  always_comb begin
    o_rdid        = '0;
    o_rs1id       = '0;
    o_rs2id       = '0;
    o_rdwen       = 1'b0;
    o_imm         = '0;
    o_exu_src_sel = EXU_SEL_REG;
    o_exu_opt     = EXU_NOP;
    o_lsu_opt     = LSU_NOP;
    o_brch        = 1'b0;
    o_jal         = 1'b0;
    o_jalr        = 1'b0;
    case (i_ins.r.opcode)
      TYPE_OP: begin
        o_rdid    = i_ins.r.rd;
        o_rs1id   = i_ins.r.rs1;
        o_rs2id   = i_ins.r.rs2;
        o_rdwen   = 1'b1;
        o_exu_opt = alu_op(funct3, alt, 1'b1);
      end
      TYPE_OPIMM: begin
        o_rdid        = i_ins.i.rd;
        o_rs1id       = i_ins.i.rs1;
        o_rdwen       = 1'b1;
        o_imm         = imm_i;
        o_exu_src_sel = EXU_SEL_IMM;
        o_exu_opt     = alu_op(funct3, alt, 1'b0);
      end
      TYPE_LUI: begin
        o_rdid        = i_ins.u.rd;
        o_rdwen       = 1'b1;
        o_imm         = imm_u;
        o_exu_src_sel = EXU_SEL_IMM;  // x0 + imm.
        o_exu_opt     = ADD;
      end
      TYPE_AUIPC: begin
        o_rdid        = i_ins.u.rd;
        o_rdwen       = 1'b1;
        o_imm         = imm_u;
        o_exu_src_sel = EXU_SEL_PCI;
        o_exu_opt     = ADD;
      end
      TYPE_LOAD: begin
        o_rdid        = i_ins.i.rd;
        o_rs1id       = i_ins.i.rs1;
        o_rdwen       = 1'b1;
        o_imm         = imm_i;
        o_exu_src_sel = EXU_SEL_IMM;  // address calc.
        o_exu_opt     = ADD;
        case (funct3)
          3'b000:  o_lsu_opt = LB;
          3'b001:  o_lsu_opt = LH;
          3'b010:  o_lsu_opt = LW;
          3'b100:  o_lsu_opt = LBU;
          3'b101:  o_lsu_opt = LHU;
          default: o_lsu_opt = LSU_NOP;
        endcase
      end
      TYPE_STORE: begin
        o_rs1id       = i_ins.s.rs1;
        o_rs2id       = i_ins.s.rs2;
        o_imm         = imm_s;
        o_exu_src_sel = EXU_SEL_IMM;
        o_exu_opt     = ADD;
        case (funct3)
          3'b000:  o_lsu_opt = SB;
          3'b001:  o_lsu_opt = SH;
          3'b010:  o_lsu_opt = SW;
          default: o_lsu_opt = LSU_NOP;
        endcase
      end
      TYPE_BRANCH: begin
        o_rs1id = i_ins.b.rs1;
        o_rs2id = i_ins.b.rs2;
        o_imm   = imm_b;
        o_brch  = 1'b1;
        case (funct3)
          3'b000:  o_exu_opt = BEQ;
          3'b001:  o_exu_opt = BNE;
          3'b100:  o_exu_opt = BLT;
          3'b101:  o_exu_opt = BGE;
          3'b110:  o_exu_opt = BLTU;
          3'b111:  o_exu_opt = BGEU;
          default: o_exu_opt = EXU_NOP;
        endcase
      end
      TYPE_JAL: begin
        o_rdid        = i_ins.j.rd;
        o_rdwen       = 1'b1;
        o_imm         = imm_j;
        o_exu_src_sel = EXU_SEL_PC4;  // link value.
        o_exu_opt     = ADD;
        o_jal         = 1'b1;
      end
      TYPE_JALR: begin
        o_rdid        = i_ins.i.rd;
        o_rs1id       = i_ins.i.rs1;
        o_rdwen       = 1'b1;
        o_imm         = imm_i;
        o_exu_src_sel = EXU_SEL_PC4;
        o_exu_opt     = ADD;
        o_jalr        = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== idu/idu_system.sv ====
`timescale 1ns/10ps
module idu_system import rv_pkg::*; (
  input  rv_ins_u              i_ins,
  output logic [CSR_ADDRW-1:0] o_csrsid,
  output logic                 o_csrsren,
  output logic [REG_ADDRW-1:0] o_rs1id,
  output logic [CPU_WIDTH-1:0] o_imm,
  output csr_opt_e             o_excsropt,
  output csr_sel_e             o_excsrsrc,
  output logic [REG_ADDRW-1:0] o_rdid,
  output logic                 o_rdwen,
  output logic [CSR_ADDRW-1:0] o_csrdid,
  output logic                 o_csrdwen
);

  logic [2:0]           funct3;
  logic [REG_ADDRW-1:0] rd, rs1;
  logic                 valid;
  csr_opt_e             opt;

  assign funct3 = i_ins.i.funct3;
  assign rd     = i_ins.i.rd;
  assign rs1    = i_ins.i.rs1;  // also uimm in the immediate forms.
  assign opt    = csr_opt_e'(funct3[1:0]);  // 01 rw, 10 rs, 11 rc.
  assign valid  = (opt != CSR_NOP);

  assign o_excsropt = opt;
  assign o_excsrsrc = funct3[2] ? CSR_SEL_IMM : CSR_SEL_REG;
  assign o_imm      = {{(CPU_WIDTH-REG_ADDRW){1'b0}}, rs1};
  assign o_rs1id    = (valid && !funct3[2]) ? rs1 : '0;
  assign o_csrsid   = i_ins.i.imm_11_0;
  assign o_csrdid   = i_ins.i.imm_11_0;
  assign o_rdid     = rd;
  assign o_rdwen    = valid && (rd != '0);

  // csrrw to x0 skips the read.
  assign o_csrsren = valid && !(opt == CSR_RW && rd == '0);

  // set / clear with zero source leaves the csr alone.
  assign o_csrdwen = (opt == CSR_RW) || (valid && rs1 != '0);

endmodule

// ==== sim.f ====
common/rv_pkg.sv
idu/idu_normal.sv
idu/idu_system.sv
idu/idu.sv
hdl/regfile.sv
hdl/csr_file.sv
hdl/id_stage.sv
testbench/tb_clk_gen.sv
testbench/tb_id_stage.sv

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/10ps
module tb_clk_gen (
  output logic o_clk,
  output logic o_reset
);

  localparam int HALF_PERIOD = 2;  // 4 ns clock.
  localparam int RESET_CYCLES = 8;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset = 1'b0;  // released off the edge.
  end

endmodule

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/10ps
module tb_id_stage import rv_pkg::*; ();

  // the directed sequence runs about 150 cycles; leave margin.
  localparam int MAX_CYCLES = 400;
  localparam logic [31:0] SEED = 32'hc61d2fd4;
  localparam logic [31:0] NOP_WORD = 32'h00000013;  // addi x0, x0, 0.

  logic        clk, reset;
  rv_ins_u     ins;
  logic [31:0] pc;
  reg_wb_t     reg_wb;
  csr_wb_t     csr_wb;
  id_ctrl_t    ctrl;
  logic [31:0] rs1_data, rs2_data, csr_rdata, trap_pc;
  logic        trap_valid;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [31:0] reg_model [32];

  tb_clk_gen u_clk_gen (
    .o_clk  (clk),
    .o_reset(reset)
  );

  id_stage id_stage_i (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_ins       (ins),
    .i_pc        (pc),
    .i_reg_wb    (reg_wb),
    .i_csr_wb    (csr_wb),
    .o_ctrl      (ctrl),
    .o_rs1_data  (rs1_data),
    .o_rs2_data  (rs2_data),
    .o_csr_rdata (csr_rdata),
    .o_trap_valid(trap_valid),
    .o_trap_pc   (trap_pc)
  );

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], TYPE_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], TYPE_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, TYPE_JAL};
  endfunction

  function automatic logic [31:0] rand_word();
    return $urandom;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = $urandom;
    return r[4:0];
  endfunction

  function automatic logic [11:0] csr_addr(input int k);
    case (k)
      0:       return CSR_MSTATUS;
      1:       return CSR_MTVEC;
      2:       return CSR_MEPC;
      default: return CSR_MCAUSE;
    endcase
  endfunction

  // expected alu op from funct3 and instruction bit 30.
  function automatic exu_opt_e ref_alu(input logic [2:0] f3, input logic b30,
                                       input logic is_reg);
    if (f3 == 3'b000) return (is_reg && b30) ? SUB : ADD;
    if (f3 == 3'b101) return b30 ? SRA : SRL;
    case (f3)
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  function automatic lsu_opt_e ref_load(input logic [2:0] f3);
    case (f3)
      3'b000:  return LB;
      3'b001:  return LH;
      3'b010:  return LW;
      3'b100:  return LBU;
      3'b101:  return LHU;
      default: return LSU_NOP;
    endcase
  endfunction

  function automatic exu_opt_e ref_branch(input logic [2:0] f3);
    case (f3)
      3'b000:  return BEQ;
      3'b001:  return BNE;
      3'b100:  return BLT;
      3'b101:  return BGE;
      3'b110:  return BLTU;
      default: return BGEU;
    endcase
  endfunction

  // csr instruction fields per the zicsr rules.
  function automatic id_ctrl_t ref_sys(input logic [11:0] csr, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    id_ctrl_t c;
    c = '0;
    c.sysins      = 1'b1;
    c.exu_src_sel = EXU_SEL_IMM;
    c.rdid        = rd;
    c.imm         = {27'b0, rs1};
    c.csrsid      = csr;
    c.csrdid      = csr;
    c.excsrsrc    = f3[2] ? CSR_SEL_IMM : CSR_SEL_REG;
    if (f3[1:0] == 2'b01) c.excsropt = CSR_RW;
    else if (f3[1:0] == 2'b10) c.excsropt = CSR_RS;
    else c.excsropt = CSR_RC;
    c.rs1id   = f3[2] ? 5'd0 : rs1;
    c.rdwen   = (rd != 5'd0);
    c.csrsren = !(f3[1:0] == 2'b01 && rd == 5'd0);  // csrrw to x0.
    c.csrdwen = (f3[1:0] == 2'b01) || (rs1 != 5'd0);
    return c;
  endfunction

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) $display("%s: pass", name);
    else $display("%s: %0d errors", name, errors - err0);
  endtask

  task automatic decode_now(input logic [31:0] word, input logic [31:0] pc_val);
    ins = word;
    pc  = pc_val;
    #1;
  endtask

  task automatic apply(input logic [31:0] word, input logic [31:0] pc_val);
    @(posedge clk);
    #1;
    decode_now(word, pc_val);
  endtask

  task automatic write_reg(input logic [4:0] id, input logic [31:0] data);
    @(posedge clk);
    #1;
    reg_wb.wen  = 1'b1;
    reg_wb.id   = id;
    reg_wb.data = data;
    decode_now(enc_r(7'd0, 5'd0, id, 3'd0, 5'd1, TYPE_OP), 32'd0);
    check_val("o_rs1_data before write", rs1_data, reg_model[id]);  // no bypass.
    @(posedge clk);
    #1;
    reg_wb = '0;
    if (id != 5'd0) reg_model[id] = data;
  endtask

  task automatic write_csr(input logic [11:0] id, input logic [31:0] data);
    @(posedge clk);
    #1;
    csr_wb.wen  = 1'b1;
    csr_wb.id   = id;
    csr_wb.data = data;
    ins         = NOP_WORD;
    @(posedge clk);
    #1;
    csr_wb = '0;
  endtask

  task automatic test_reset();
    int err0;
    err0 = errors;
    for (int k = 0; k < 16; k++) begin
      apply(enc_r(7'd0, 5'(2 * k + 1), 5'(2 * k), 3'd0, 5'd1, TYPE_OP), 32'd0);
      check_val("o_rs1_data", rs1_data, 32'd0);
      check_val("o_rs2_data", rs2_data, 32'd0);
      check_val("o_trap_valid", trap_valid, 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
      apply(enc_i(csr_addr(k), 5'd0, 3'b010, 5'd1, TYPE_SYS), 32'd0);
      check_val("o_csr_rdata", csr_rdata, 32'd0);
      check_val("o_trap_valid", trap_valid, 1'b0);
    end
    write_reg(5'd0, rand_word());
    decode_now(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd1, TYPE_OP), 32'd0);
    check_val("o_rs1_data x0", rs1_data, 32'd0);
    report_test("reset", err0);
  endtask

  task automatic test_alu();
    int          err0;
    id_ctrl_t    exp;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [31:0] w;
    logic [11:0] imm12;
    err0 = errors;
    for (int n = 0; n < 12; n++) begin
      rd  = rand_reg();
      rs1 = rand_reg();
      rs2 = rand_reg();
      w   = rand_word();
      f3  = w[2:0];
      exp = '0;
      exp.rdid    = rd;
      exp.rs1id   = rs1;
      exp.rs2id   = rs2;
      exp.rdwen   = 1'b1;
      exp.exu_opt = ref_alu(f3, w[8], 1'b1);
      apply(enc_r({1'b0, w[8], 5'd0}, rs2, rs1, f3, rd, TYPE_OP), rand_word());
      check_val("o_ctrl op", ctrl, exp);
    end
    for (int n = 0; n < 12; n++) begin
      rd  = rand_reg();
      rs1 = rand_reg();
      w   = rand_word();
      f3  = w[2:0];
      if (f3 == 3'b001) imm12 = {7'd0, w[20:16]};  // slli shamt.
      else if (f3 == 3'b101) imm12 = {1'b0, w[8], 5'd0, w[20:16]};
      else imm12 = w[31:20];
      exp = '0;
      exp.rdid        = rd;
      exp.rs1id       = rs1;
      exp.rdwen       = 1'b1;
      exp.imm         = {{20{imm12[11]}}, imm12};
      exp.exu_src_sel = EXU_SEL_IMM;
      exp.exu_opt     = ref_alu(f3, imm12[10], 1'b0);
      apply(enc_i(imm12, rs1, f3, rd, TYPE_OPIMM), rand_word());
      check_val("o_ctrl opimm", ctrl, exp);
    end
    for (int n = 0; n < 6; n++) begin
      rd  = rand_reg();
      w   = rand_word();
      exp = '0;
      exp.rdid        = rd;
      exp.rdwen       = 1'b1;
      exp.imm         = {w[31:12], 12'd0};
      exp.exu_opt     = ADD;
      exp.exu_src_sel = (n < 3) ? EXU_SEL_IMM : EXU_SEL_PCI;  // lui then auipc.
      apply({w[31:12], rd, (n < 3) ? TYPE_LUI : TYPE_AUIPC}, rand_word());
      check_val("o_ctrl upper", ctrl, exp);
    end
    report_test("alu_decode", err0);
  endtask

  task automatic test_mem_flow();
    int          err0;
    id_ctrl_t    exp;
    logic [4:0]  rd, rs1, rs2;
    logic [31:0] w;
    logic [11:0] imm12;
    logic [12:0] imm13;
    logic [20:0] imm21;
    err0 = errors;
    for (int f = 0; f < 8; f++) begin
      if (f == 3 || f >= 6) continue;
      rd    = rand_reg();
      rs1   = rand_reg();
      w     = rand_word();
      imm12 = (f == 0) ? 12'hffc : w[11:0];
      exp   = '0;
      exp.rdid        = rd;
      exp.rs1id       = rs1;
      exp.rdwen       = 1'b1;
      exp.imm         = {{20{imm12[11]}}, imm12};
      exp.exu_src_sel = EXU_SEL_IMM;
      exp.exu_opt     = ADD;
      exp.lsu_opt     = ref_load(3'(f));
      apply(enc_i(imm12, rs1, 3'(f), rd, TYPE_LOAD), 32'd0);
      check_val("o_ctrl load", ctrl, exp);
    end
    for (int f = 0; f < 3; f++) begin
      rs1   = rand_reg();
      rs2   = rand_reg();
      w     = rand_word();
      imm12 = (f == 0) ? 12'h800 : w[11:0];
      exp   = '0;
      exp.rs1id       = rs1;
      exp.rs2id       = rs2;
      exp.imm         = {{20{imm12[11]}}, imm12};
      exp.exu_src_sel = EXU_SEL_IMM;
      exp.exu_opt     = ADD;
      exp.lsu_opt     = (f == 0) ? SB : ((f == 1) ? SH : SW);
      apply(enc_s(imm12, rs2, rs1, 3'(f)), 32'd0);
      check_val("o_ctrl store", ctrl, exp);
    end
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      rs1   = rand_reg();
      rs2   = rand_reg();
      w     = rand_word();
      imm13 = (f == 0) ? 13'h1ff0 : {w[11:0], 1'b0};  // -16 first.
      exp   = '0;
      exp.rs1id   = rs1;
      exp.rs2id   = rs2;
      exp.imm     = {{19{imm13[12]}}, imm13};
      exp.brch    = 1'b1;
      exp.exu_opt = ref_branch(3'(f));
      apply(enc_b(imm13, rs2, rs1, 3'(f)), 32'd0);
      check_val("o_ctrl branch", ctrl, exp);
    end
    for (int n = 0; n < 2; n++) begin
      rd    = rand_reg();
      w     = rand_word();
      imm21 = (n == 0) ? 21'h1ffff8 : {w[19:0], 1'b0};
      exp   = '0;
      exp.rdid        = rd;
      exp.rdwen       = 1'b1;
      exp.imm         = {{11{imm21[20]}}, imm21};
      exp.exu_src_sel = EXU_SEL_PC4;
      exp.exu_opt     = ADD;
      exp.jal         = 1'b1;
      apply(enc_j(imm21, rd), 32'd0);
      check_val("o_ctrl jal", ctrl, exp);
    end
    rd    = rand_reg();
    rs1   = rand_reg();
    w     = rand_word();
    imm12 = w[11:0];
    exp   = '0;
    exp.rdid        = rd;
    exp.rs1id       = rs1;
    exp.rdwen       = 1'b1;
    exp.imm         = {{20{imm12[11]}}, imm12};
    exp.exu_src_sel = EXU_SEL_PC4;
    exp.exu_opt     = ADD;
    exp.jalr        = 1'b1;
    apply(enc_i(imm12, rs1, 3'd0, rd, TYPE_JALR), 32'd0);
    check_val("o_ctrl jalr", ctrl, exp);
    report_test("mem_flow_decode", err0);
  endtask

  task automatic test_regfile();
    int         err0;
    logic [4:0] id, other;
    err0 = errors;
    for (int n = 0; n < 10; n++) begin
      id    = rand_reg();
      other = rand_reg();
      write_reg(id, rand_word());
      decode_now(enc_r(7'd0, other, id, 3'd0, 5'd1, TYPE_OP), 32'd0);
      check_val("o_rs1_data", rs1_data, reg_model[id]);
      check_val("o_rs2_data", rs2_data, reg_model[other]);
    end
    for (int k = 0; k < 16; k++) begin
      apply(enc_r(7'd0, 5'(2 * k + 1), 5'(2 * k), 3'd0, 5'd1, TYPE_OP), 32'd0);
      check_val("o_rs1_data", rs1_data, reg_model[2 * k]);
      check_val("o_rs2_data", rs2_data, reg_model[2 * k + 1]);
    end
    report_test("regfile", err0);
  endtask

  task automatic test_csr();
    int          err0;
    logic [4:0]  rd, rs1;
    logic [11:0] csr;
    logic [31:0] w;
    err0 = errors;
    for (int f = 1; f < 8; f++) begin
      if (f == 4) continue;
      for (int v = 0; v < 3; v++) begin
        w   = rand_word();
        rd  = (v == 1) ? 5'd0 : 5'(w[3:0] + 4'd1);    // v1 reads into x0.
        rs1 = (v == 2) ? 5'd0 : 5'(w[7:4] + 4'd1);    // v2 has zero source.
        csr = csr_addr(int'(w[9:8]));
        apply(enc_i(csr, rs1, 3'(f), rd, TYPE_SYS), 32'd0);
        check_val("o_ctrl csr", ctrl, ref_sys(csr, rs1, 3'(f), rd));
        check_val("o_trap_valid", trap_valid, 1'b0);
      end
    end
    for (int k = 0; k < 4; k++) begin
      w = rand_word();
      write_csr(csr_addr(k), w);
      decode_now(enc_i(csr_addr(k), 5'd0, 3'b010, 5'd1, TYPE_SYS), 32'd0);
      check_val("o_csr_rdata", csr_rdata, w);
    end
    apply(enc_i(12'h7c0, 5'd0, 3'b010, 5'd1, TYPE_SYS), 32'd0);
    check_val("o_csr_rdata unknown", csr_rdata, 32'd0);
    report_test("csr", err0);
  endtask

  task automatic test_trap();
    int          err0;
    id_ctrl_t    exp;
    logic [31:0] tvec, epc;
    err0 = errors;
    tvec = rand_word() & 32'hffff_fffc;
    epc  = rand_word() & 32'hffff_fffc;
    write_csr(CSR_MTVEC, tvec);
    decode_now(enc_i(12'h000, 5'd0, 3'd0, 5'd0, TYPE_SYS), epc);  // ecall.
    exp = '0;
    exp.sysins      = 1'b1;
    exp.exu_src_sel = EXU_SEL_IMM;
    exp.ecall       = 1'b1;
    check_val("o_ctrl ecall", ctrl, exp);
    check_val("o_trap_valid", trap_valid, 1'b1);
    check_val("o_trap_pc", trap_pc, tvec);
    apply(enc_i(CSR_MEPC, 5'd0, 3'b010, 5'd1, TYPE_SYS), 32'd0);
    check_val("o_csr_rdata mepc", csr_rdata, epc);
    apply(enc_i(CSR_MCAUSE, 5'd0, 3'b010, 5'd1, TYPE_SYS), 32'd0);
    check_val("o_csr_rdata mcause", csr_rdata, 32'd11);
    apply(enc_i(12'h302, 5'd0, 3'd0, 5'd0, TYPE_SYS), 32'd0);  // mret.
    exp = '0;
    exp.sysins      = 1'b1;
    exp.exu_src_sel = EXU_SEL_IMM;
    exp.csrsid      = 12'h302;
    exp.csrdid      = 12'h302;
    exp.mret        = 1'b1;
    check_val("o_ctrl mret", ctrl, exp);
    check_val("o_trap_valid", trap_valid, 1'b1);
    check_val("o_trap_pc", trap_pc, epc);
    apply(NOP_WORD, 32'd0);
    check_val("o_trap_valid", trap_valid, 1'b0);
    report_test("trap", err0);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(SEED));
    ins    = NOP_WORD;
    pc     = '0;
    reg_wb = '0;
    csr_wb = '0;
    for (int k = 0; k < 32; k++) begin
      reg_model[k] = '0;
    end
    wait (reset == 1'b0);
    test_reset();
    test_alu();
    test_mem_flow();
    test_regfile();
    test_csr();
    test_trap();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
